/* logic/vmul_pkg.sv */
// vector multiply unit package
// shared widths, vector types and the operation and element-width encodings

package vmul_pkg;

    ////////////////////////////////////////////////////////////
    // widths

    // vector register and datapath word
    localparam int unsigned VREG_W         = 128;
    localparam int unsigned OP_W           = 32;
    localparam int unsigned WORDS_PER_VREG = VREG_W / OP_W;

    // byte counts, one enable bit per byte
    localparam int unsigned VREG_BYTES = VREG_W / 8;
    localparam int unsigned WORD_BYTES = OP_W / 8;

    // vl holds 0 up to 16 elements
    localparam int unsigned VL_W        = 5;
    localparam int unsigned VREG_ADDR_W = 5;

    ////////////////////////////////////////////////////////////
    // vector types

    typedef logic [VREG_W-1:0]                     vreg_t;
    typedef logic [VREG_BYTES-1:0]                 vreg_mask_t;
    typedef logic [OP_W-1:0]                       word_t;
    typedef logic [WORD_BYTES-1:0]                 word_mask_t;
    typedef logic [VREG_ADDR_W-1:0]                vreg_addr_t;
    typedef logic [VL_W-1:0]                       vl_t;
    typedef logic [$clog2(WORDS_PER_VREG)-1:0]     word_idx_t;

    // index of the final word of a register
    localparam word_idx_t LAST_WORD = word_idx_t'(WORDS_PER_VREG - 1);

    ////////////////////////////////////////////////////////////
    // encodings

    // element width, the value is log2 of the element bytes
    typedef enum logic [1:0] {
        VSEW_8  = 2'd0,
        VSEW_16 = 2'd1,
        VSEW_32 = 2'd2
    } vsew_e;

    typedef enum logic [2:0] {
        MUL_VMUL    = 3'd0,
        MUL_VMULH   = 3'd1,
        MUL_VMULHU  = 3'd2,
        MUL_VMULHSU = 3'd3,
        MUL_VMACC   = 3'd4,
        MUL_VNMSAC  = 3'd5
    } mul_op_e;

    // issue sequencer
    typedef enum logic {
        IDLE = 1'b0,
        BUSY = 1'b1
    } fetch_state_e;

endpackage

/* logic/vmul_if.sv */
// stage interfaces of the vector multiply unit
// operand words into the lanes and result words out of them

`timescale 1ns/1ps

interface vmul_operand_if import vmul_pkg::*; ();
    logic       valid;
    mul_op_e    op;
    vsew_e      sew;
    word_t      opa;
    word_t      opb;
    word_t      acc;
    word_mask_t byte_en;
    logic       last;
    vreg_addr_t vd;

    modport src (output valid, op, sew, opa, opb, acc, byte_en, last, vd);
    modport dst (input  valid, op, sew, opa, opb, acc, byte_en, last, vd);
endinterface

interface vmul_result_if import vmul_pkg::*; ();
    logic       valid;
    word_t      word;
    word_mask_t byte_en;
    logic       last;
    vreg_addr_t vd;

    modport src (output valid, word, byte_en, last, vd);
    modport dst (input  valid, word, byte_en, last, vd);
endinterface

/* logic/vmul_operand_fetch.sv */
// operand fetch of the vector multiply unit
// accepts operations, reads vs1/vs2/vd and streams them out one word per cycle

`timescale 1ns/1ps

module vmul_operand_fetch import vmul_pkg::*; (
    input  logic           clk_i,
    input  logic           async_rst_ni,

    input  logic           op_rdy_i,
    output logic           op_ack_o,
    input  mul_op_e        op_i,
    input  vsew_e          vsew_i,
    input  vl_t            vl_i,
    input  vreg_addr_t     vs1_i,
    input  vreg_addr_t     vs2_i,
    input  vreg_addr_t     vd_i,

    output vreg_addr_t     vreg_rd1_addr_o,
    output vreg_addr_t     vreg_rd2_addr_o,
    output vreg_addr_t     vreg_rd3_addr_o,
    input  vreg_t          vreg_rd1_i,
    input  vreg_t          vreg_rd2_i,
    input  vreg_t          vreg_rd3_i,

    vmul_operand_if.src    opd
);

    fetch_state_e state_q, state_d;
    word_idx_t    cnt_q, cnt_d;
    logic         busy;

    // operation latched at acceptance
    mul_op_e      op_q;
    vsew_e        sew_q;
    vl_t          vl_q;
    vreg_addr_t   vs1_q, vs2_q, vd_q;

    vreg_t        vs1_sh_q, vs2_sh_q, vd_sh_q;

    // per-word side information, one cycle behind the counter
    logic         opd_valid_q;
    logic         opd_last_q;
    mul_op_e      opd_op_q;
    vsew_e        opd_sew_q;
    vreg_addr_t   opd_vd_q;
    word_mask_t   opd_byte_en_q, byte_en_d;
    logic [$clog2(VREG_BYTES)-1:0] byte_idx;
    logic [$clog2(VREG_BYTES)-1:0] elem_idx;

    ////////////////////////////////////////////////////////////
    // issue sequencer

    assign busy     = (state_q == BUSY);
    // a new op may enter in the final busy cycle
    assign op_ack_o = op_rdy_i & (~busy | (cnt_q == LAST_WORD));

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        if (op_ack_o) begin
            state_d = BUSY;
            cnt_d   = '0;
        end else if (busy) begin
            if (cnt_q == LAST_WORD) begin
                state_d = IDLE;
            end
            cnt_d = cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q     <= IDLE;
            cnt_q       <= '0;
            opd_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            cnt_q       <= cnt_d;
            opd_valid_q <= busy;
        end
    end

    always_ff @(posedge clk_i) begin
        if (op_ack_o) begin
            op_q  <= op_i;
            sew_q <= vsew_i;
            vl_q  <= vl_i;
            vs1_q <= vs1_i;
            vs2_q <= vs2_i;
            vd_q  <= vd_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // register reads and operand shift registers

    assign vreg_rd1_addr_o = vs1_q;
    assign vreg_rd2_addr_o = vs2_q;
    assign vreg_rd3_addr_o = vd_q;

    // load in the first busy cycle, afterwards drop the lowest word
    always_ff @(posedge clk_i) begin
        if (busy && (cnt_q == '0)) begin
            vs1_sh_q <= vreg_rd1_i;
            vs2_sh_q <= vreg_rd2_i;
            vd_sh_q  <= vreg_rd3_i;
        end else begin
            vs1_sh_q <= vs1_sh_q >> OP_W;
            vs2_sh_q <= vs2_sh_q >> OP_W;
            vd_sh_q  <= vd_sh_q >> OP_W;
        end
    end

    // byte enabled when its element index is below vl
    always_comb begin
        for (int j = 0; j < WORD_BYTES; j++) begin
            byte_idx     = {cnt_q, j[1:0]};
            elem_idx     = byte_idx >> sew_q;
            byte_en_d[j] = ({1'b0, elem_idx} < vl_q);
        end
    end

    always_ff @(posedge clk_i) begin
        opd_last_q    <= (cnt_q == LAST_WORD);
        opd_op_q      <= op_q;
        opd_sew_q     <= sew_q;
        opd_vd_q      <= vd_q;
        opd_byte_en_q <= byte_en_d;
    end

    assign opd.valid   = opd_valid_q;
    assign opd.op      = opd_op_q;
    assign opd.sew     = opd_sew_q;
    assign opd.opa     = vs1_sh_q[OP_W-1:0];
    assign opd.opb     = vs2_sh_q[OP_W-1:0];
    assign opd.acc     = vd_sh_q[OP_W-1:0];
    assign opd.byte_en = opd_byte_en_q;
    assign opd.last    = opd_last_q;
    assign opd.vd      = opd_vd_q;

endmodule

/* logic/vmul_lanes.sv */
// multiply lanes of the vector multiply unit
// extends, multiplies and accumulates per element in two register stages

`timescale 1ns/1ps

module vmul_lanes import vmul_pkg::*; (
    input  logic           clk_i,
    input  logic           async_rst_ni,

    vmul_operand_if.dst    opd,
    vmul_result_if.src     res
);

    // one full-width product per element slot
    typedef logic [2*OP_W-1:0] prod_t;

    // element idx of a word, sign- or zero-extended to product width
    function automatic prod_t extend_elem(input word_t w, input vsew_e sew,
                                          input logic [1:0] idx, input logic sgn);
        prod_t r;
        case (sew)
            VSEW_8:  r = {{(2*OP_W-8){sgn & w[8*idx+7]}}, w[8*idx +: 8]};
            VSEW_16: r = {{(2*OP_W-16){sgn & w[16*idx[0]+15]}}, w[16*idx[0] +: 16]};
            default: r = {{OP_W{sgn & w[OP_W-1]}}, w};
        endcase
        return r;
    endfunction

    logic       sgn_a, sgn_b;
    prod_t      a_ext [WORD_BYTES];
    prod_t      b_ext [WORD_BYTES];
    prod_t      c_ext [WORD_BYTES];

    logic       s1_valid_q, s2_valid_q;
    mul_op_e    s1_op_q, s2_op_q;
    vsew_e      s1_sew_q, s2_sew_q;
    word_mask_t s1_byte_en_q, s2_byte_en_q;
    logic       s1_last_q, s2_last_q;
    vreg_addr_t s1_vd_q, s2_vd_q;
    prod_t      s1_a_q [WORD_BYTES];
    prod_t      s1_b_q [WORD_BYTES];
    prod_t      s1_c_q [WORD_BYTES];

    prod_t      mul_raw [WORD_BYTES];
    prod_t      prod_d  [WORD_BYTES];
    prod_t      prod_q  [WORD_BYTES];
    logic       high;
    word_t      res_word;

    ////////////////////////////////////////////////////////////
    // stage 1, operand extension

    // vs1 is opa and vs2 is opb, low-half ops do not care
    assign sgn_a = (opd.op == MUL_VMULH);
    assign sgn_b = (opd.op == MUL_VMULH) | (opd.op == MUL_VMULHSU);

    always_comb begin
        for (int i = 0; i < WORD_BYTES; i++) begin
            a_ext[i] = extend_elem(opd.opa, opd.sew, 2'(i), sgn_a);
            b_ext[i] = extend_elem(opd.opb, opd.sew, 2'(i), sgn_b);
            c_ext[i] = extend_elem(opd.acc, opd.sew, 2'(i), 1'b0);
        end
    end

    always_ff @(posedge clk_i) begin
        s1_op_q      <= opd.op;
        s1_sew_q     <= opd.sew;
        s1_byte_en_q <= opd.byte_en;
        s1_last_q    <= opd.last;
        s1_vd_q      <= opd.vd;
        for (int i = 0; i < WORD_BYTES; i++) begin
            s1_a_q[i] <= a_ext[i];
            s1_b_q[i] <= b_ext[i];
            s1_c_q[i] <= c_ext[i];
        end
    end

    ////////////////////////////////////////////////////////////
    // stage 2, multiply and accumulate

    always_comb begin
        for (int i = 0; i < WORD_BYTES; i++) begin
            mul_raw[i] = s1_a_q[i] * s1_b_q[i];
            case (s1_op_q)
                MUL_VMACC:  prod_d[i] = s1_c_q[i] + mul_raw[i];
                MUL_VNMSAC: prod_d[i] = s1_c_q[i] - mul_raw[i];
                default:    prod_d[i] = mul_raw[i];
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        s2_op_q      <= s1_op_q;
        s2_sew_q     <= s1_sew_q;
        s2_byte_en_q <= s1_byte_en_q;
        s2_last_q    <= s1_last_q;
        s2_vd_q      <= s1_vd_q;
        for (int i = 0; i < WORD_BYTES; i++) begin
            prod_q[i] <= prod_d[i];
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= opd.valid;
            s2_valid_q <= s1_valid_q;
        end
    end

    // pick low or high half of each element product
    assign high = (s2_op_q == MUL_VMULH) | (s2_op_q == MUL_VMULHU) | (s2_op_q == MUL_VMULHSU);

    always_comb begin
        res_word = '0;
        case (s2_sew_q)
            VSEW_8: begin
                for (int i = 0; i < 4; i++) begin
                    res_word[8*i +: 8] = high ? prod_q[i][15:8] : prod_q[i][7:0];
                end
            end
            VSEW_16: begin
                for (int i = 0; i < 2; i++) begin
                    res_word[16*i +: 16] = high ? prod_q[i][31:16] : prod_q[i][15:0];
                end
            end
            default: res_word = high ? prod_q[0][2*OP_W-1:OP_W] : prod_q[0][OP_W-1:0];
        endcase
    end

    assign res.valid   = s2_valid_q;
    assign res.word    = res_word;
    assign res.byte_en = s2_byte_en_q;
    assign res.last    = s2_last_q;
    assign res.vd      = s2_vd_q;

endmodule

/* logic/vmul_result_pack.sv */
// result packing of the vector multiply unit
// gathers four result words into one register write with its byte mask

`timescale 1ns/1ps

module vmul_result_pack import vmul_pkg::*; (
    input  logic           clk_i,
    input  logic           async_rst_ni,

    vmul_result_if.dst     res,

    output logic           vreg_wr_en_o,
    output vreg_addr_t     vreg_wr_addr_o,
    output vreg_t          vreg_wr_o,
    output vreg_mask_t     vreg_wr_mask_o
);

    // words enter at the top, word 0 ends up lowest
    vreg_t      data_sh_q;
    vreg_mask_t mask_sh_q;

    logic       wr_en_q;
    vreg_addr_t wr_addr_q;

    ////////////////////////////////////////////////////////////
    // result shift register

    always_ff @(posedge clk_i) begin
        if (res.valid) begin
            data_sh_q <= {res.word, data_sh_q[VREG_W-1:OP_W]};
            mask_sh_q <= {res.byte_en, mask_sh_q[VREG_BYTES-1:WORD_BYTES]};
        end
    end

    ////////////////////////////////////////////////////////////
    // register-file write

    // write fires the cycle after the last word went in
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= res.valid & res.last;
        end
    end

    always_ff @(posedge clk_i) begin
        if (res.valid && res.last) begin
            wr_addr_q <= res.vd;
        end
    end

    // the shift register still holds the full register during the write,
    // the next op's first word only shifts in at its end
    assign vreg_wr_en_o   = wr_en_q;
    assign vreg_wr_addr_o = wr_addr_q;
    assign vreg_wr_o      = data_sh_q;
    // no bytes enabled outside the write cycle
    assign vreg_wr_mask_o = wr_en_q ? mask_sh_q : '0;

endmodule

/* logic/vmul_unit.sv */
// vector integer multiply unit, top level
// operand fetch, multiply lanes and result packing in a fixed 8-cycle pipe

`timescale 1ns/1ps

module vmul_unit import vmul_pkg::*; (
    input  logic           clk_i,
    input  logic           async_rst_ni,

    // issue
    input  logic           op_rdy_i,
    output logic           op_ack_o,
    input  mul_op_e        op_i,
    input  vsew_e          vsew_i,
    input  vl_t            vl_i,
    input  vreg_addr_t     vs1_i,
    input  vreg_addr_t     vs2_i,
    input  vreg_addr_t     vd_i,

    // register-file reads for vs1, vs2 and the old vd
    output vreg_addr_t     vreg_rd1_addr_o,
    input  vreg_t          vreg_rd1_i,
    output vreg_addr_t     vreg_rd2_addr_o,
    input  vreg_t          vreg_rd2_i,
    output vreg_addr_t     vreg_rd3_addr_o,
    input  vreg_t          vreg_rd3_i,

    // register-file write
    output logic           vreg_wr_en_o,
    output vreg_addr_t     vreg_wr_addr_o,
    output vreg_t          vreg_wr_o,
    output vreg_mask_t     vreg_wr_mask_o
);

    vmul_operand_if opd_if ();
    vmul_result_if  res_if ();

    vmul_operand_fetch u_operand_fetch (
        .clk_i           (clk_i),
        .async_rst_ni    (async_rst_ni),
        .op_rdy_i        (op_rdy_i),
        .op_ack_o        (op_ack_o),
        .op_i            (op_i),
        .vsew_i          (vsew_i),
        .vl_i            (vl_i),
        .vs1_i           (vs1_i),
        .vs2_i           (vs2_i),
        .vd_i            (vd_i),
        .vreg_rd1_addr_o (vreg_rd1_addr_o),
        .vreg_rd2_addr_o (vreg_rd2_addr_o),
        .vreg_rd3_addr_o (vreg_rd3_addr_o),
        .vreg_rd1_i      (vreg_rd1_i),
        .vreg_rd2_i      (vreg_rd2_i),
        .vreg_rd3_i      (vreg_rd3_i),
        .opd             (opd_if.src)
    );

    vmul_lanes u_lanes (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .opd          (opd_if.dst),
        .res          (res_if.src)
    );

    vmul_result_pack u_result_pack (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .res            (res_if.dst),
        .vreg_wr_en_o   (vreg_wr_en_o),
        .vreg_wr_addr_o (vreg_wr_addr_o),
        .vreg_wr_o      (vreg_wr_o),
        .vreg_wr_mask_o (vreg_wr_mask_o)
    );

endmodule

/* bench/vmul_tb_tasks.svh */
// directed tests for the vector multiply unit
// included into the testbench top

`ifndef VMUL_TB_TASKS_SVH
`define VMUL_TB_TASKS_SVH

////////////////////////////////////////////////////////////
// issue and check helpers

// hold op_rdy_i until the unit accepts
// ack_cycle stays -1 on timeout
task automatic issue_op(input mul_op_e op, input vsew_e sew, input vl_t vl,
                        input vreg_addr_t vs1, input vreg_addr_t vs2,
                        input vreg_addr_t vd, output int ack_cycle);
    int n;
    n         = 0;
    ack_cycle = -1;
    @(negedge clk_i);
    op_rdy_i = 1'b1;
    op_i     = op;
    vsew_i   = sew;
    vl_i     = vl;
    vs1_i    = vs1;
    vs2_i    = vs2;
    vd_i     = vd;
    // op_ack_o is combinational so look shortly after the falling edge
    while (ack_cycle < 0 && n < ACK_TIMEOUT) begin
        #1;
        if (op_ack_o) begin
            ack_cycle = cycle_cnt;
        end else begin
            @(negedge clk_i);
            n++;
        end
    end
    if (ack_cycle < 0) begin
        $display("op_ack_o did not rise within %0d cycles for op %0d", ACK_TIMEOUT, op);
        err_cnt++;
    end
    @(negedge clk_i);
    op_rdy_i = 1'b0;
    // read addresses follow the accepted operation in the first busy cycle
    if (ack_cycle >= 0) begin
        if (vreg_rd1_addr_o !== vs1) begin
            $display("Fail vreg_rd1_addr_o: got %h expected %h", vreg_rd1_addr_o, vs1);
            err_cnt++;
        end
        if (vreg_rd2_addr_o !== vs2) begin
            $display("Fail vreg_rd2_addr_o: got %h expected %h", vreg_rd2_addr_o, vs2);
            err_cnt++;
        end
        if (vreg_rd3_addr_o !== vd) begin
            $display("Fail vreg_rd3_addr_o: got %h expected %h", vreg_rd3_addr_o, vd);
            err_cnt++;
        end
    end
endtask

task automatic await_write(input int ack_cycle, input vreg_addr_t vd, input vreg_t exp_data,
                           input vreg_mask_t exp_mask, input vreg_t old_vd);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < WR_TIMEOUT) begin
        @(negedge clk_i);
        n++;
        seen = vreg_wr_en_o;
    end
    if (!seen) begin
        $display("no register write within %0d cycles of the ack", WR_TIMEOUT);
        err_cnt++;
    end else begin
        if (cycle_cnt - ack_cycle != 8) begin
            $display("write came %0d cycles after the ack, not 8", cycle_cnt - ack_cycle);
            err_cnt++;
        end
        if (vreg_wr_addr_o !== vd) begin
            $display("Fail vreg_wr_addr_o: got %h expected %h", vreg_wr_addr_o, vd);
            err_cnt++;
        end
        if (vreg_wr_mask_o !== exp_mask) begin
            $display("Fail vreg_wr_mask_o: got %h expected %h", vreg_wr_mask_o, exp_mask);
            err_cnt++;
        end
        if (merge_bytes('0, vreg_wr_o, exp_mask) !== merge_bytes('0, exp_data, exp_mask)) begin
            $display("Fail vreg_wr_o: got %h expected %h",
                     merge_bytes('0, vreg_wr_o, exp_mask), merge_bytes('0, exp_data, exp_mask));
            err_cnt++;
        end
        // model takes the write on the next rising edge
        @(negedge clk_i);
        // the write lasts a single cycle
        if (vreg_wr_en_o !== 1'b0) begin
            $display("Fail vreg_wr_en_o: got %h expected %h", vreg_wr_en_o, 1'b0);
            err_cnt++;
        end
        if (vregs[vd] !== merge_bytes(old_vd, exp_data, exp_mask)) begin
            $display("Fail vregs[%0d]: got %h expected %h", vd, vregs[vd],
                     merge_bytes(old_vd, exp_data, exp_mask));
            err_cnt++;
        end
    end
endtask

task automatic exec_op(input mul_op_e op, input vsew_e sew, input vl_t vl,
                       input vreg_addr_t vs1, input vreg_addr_t vs2, input vreg_addr_t vd);
    vreg_t      exp_data;
    vreg_t      old_vd;
    vreg_mask_t exp_mask;
    int         ack_cycle;
    old_vd   = vregs[vd];
    exp_data = ref_result(op, sew, vregs[vs1], vregs[vs2], old_vd);
    exp_mask = ref_mask(sew, vl);
    issue_op(op, sew, vl, vs1, vs2, vd, ack_cycle);
    if (ack_cycle >= 0) await_write(ack_cycle, vd, exp_data, exp_mask, old_vd);
endtask

////////////////////////////////////////////////////////////
// tests

task automatic reset_quiet();
    repeat (5) begin
        @(negedge clk_i);
        if (op_ack_o !== 1'b0) begin
            $display("Fail op_ack_o: got %h expected %h", op_ack_o, 1'b0);
            err_cnt++;
        end
        if (vreg_wr_en_o !== 1'b0) begin
            $display("Fail vreg_wr_en_o: got %h expected %h", vreg_wr_en_o, 1'b0);
            err_cnt++;
        end
    end
endtask

task automatic low_products();
    exec_op(MUL_VMUL, VSEW_8, 5'd16, 5'd1, 5'd2, 5'd3);
    exec_op(MUL_VMUL, VSEW_16, 5'd8, 5'd4, 5'd5, 5'd6);
    exec_op(MUL_VMUL, VSEW_32, 5'd4, 5'd7, 5'd8, 5'd9);
endtask

task automatic high_products();
    mul_op_e ops [3];
    vsew_e   sews [3];
    ops  = '{MUL_VMULH, MUL_VMULHU, MUL_VMULHSU};
    sews = '{VSEW_8, VSEW_16, VSEW_32};
    // negative extremes and all-ones in every element width
    vregs[20] = 128'h8000_0000_7fff_ffff_8000_ffff_80ff_7f01;
    vregs[21] = 128'hffff_ffff_8000_0000_8000_8000_8080_ff80;
    for (int o = 0; o < 3; o++) begin
        for (int s = 0; s < 3; s++) begin
            exec_op(ops[o], sews[s], vl_t'(16 >> s), 5'd20, 5'd21, 5'd22);
            exec_op(ops[o], sews[s], vl_t'(16 >> s), 5'd10, 5'd11, 5'd23);
        end
    end
endtask

task automatic accumulate_ops();
    exec_op(MUL_VMACC, VSEW_8, 5'd16, 5'd12, 5'd13, 5'd14);
    exec_op(MUL_VNMSAC, VSEW_8, 5'd16, 5'd12, 5'd13, 5'd15);
    exec_op(MUL_VMACC, VSEW_16, 5'd8, 5'd20, 5'd21, 5'd16);
    exec_op(MUL_VNMSAC, VSEW_16, 5'd8, 5'd20, 5'd21, 5'd17);
    exec_op(MUL_VMACC, VSEW_32, 5'd4, 5'd21, 5'd20, 5'd18);
    exec_op(MUL_VNMSAC, VSEW_32, 5'd4, 5'd12, 5'd20, 5'd19);
endtask

task automatic partial_vl_masks();
    exec_op(MUL_VMUL, VSEW_8, 5'd5, 5'd1, 5'd2, 5'd26);
    exec_op(MUL_VMACC, VSEW_16, 5'd3, 5'd4, 5'd5, 5'd27);
    exec_op(MUL_VMULH, VSEW_32, 5'd1, 5'd20, 5'd21, 5'd28);
    // vl of 0 still writes but enables no byte
    exec_op(MUL_VNMSAC, VSEW_8, 5'd0, 5'd7, 5'd8, 5'd29);
endtask

task automatic back_to_back();
    vreg_t exp_a, exp_b, old_a, old_b;
    int    ack_a, ack_b;
    old_a = vregs[24];
    old_b = vregs[25];
    exp_a = ref_result(MUL_VMUL, VSEW_16, vregs[12], vregs[13], old_a);
    exp_b = ref_result(MUL_VMACC, VSEW_32, vregs[14], vregs[15], old_b);
    issue_op(MUL_VMUL, VSEW_16, 5'd8, 5'd12, 5'd13, 5'd24, ack_a);
    issue_op(MUL_VMACC, VSEW_32, 5'd4, 5'd14, 5'd15, 5'd25, ack_b);
    if (ack_a >= 0 && ack_b >= 0) begin
        if (ack_b - ack_a != 4) begin
            $display("second ack came %0d cycles after the first, not 4", ack_b - ack_a);
            err_cnt++;
        end
        await_write(ack_a, 5'd24, exp_a, ref_mask(VSEW_16, 5'd8), old_a);
        await_write(ack_b, 5'd25, exp_b, ref_mask(VSEW_32, 5'd4), old_b);
    end
endtask

`endif

/* bench/vmul_tb.sv */
// testbench for the vector multiply unit
// register-file model, element reference model and directed tests

`timescale 1ns/1ps

module vmul_tb import vmul_pkg::*; ();

    localparam int ACK_TIMEOUT = 20;
    localparam int WR_TIMEOUT  = 20;

    logic       clk_i;
    logic       async_rst_ni;
    logic       op_rdy_i;
    logic       op_ack_o;
    mul_op_e    op_i;
    vsew_e      vsew_i;
    vl_t        vl_i;
    vreg_addr_t vs1_i, vs2_i, vd_i;
    vreg_addr_t vreg_rd1_addr_o, vreg_rd2_addr_o, vreg_rd3_addr_o;
    vreg_t      vreg_rd1_i, vreg_rd2_i, vreg_rd3_i;
    logic       vreg_wr_en_o;
    vreg_addr_t vreg_wr_addr_o;
    vreg_t      vreg_wr_o;
    vreg_mask_t vreg_wr_mask_o;

    vreg_t      vregs [32];
    int         err_cnt;
    int         cycle_cnt;

    initial clk_i = 1'b0;
    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    ////////////////////////////////////////////////////////////
    // register-file model, combinational reads, byte-masked write

    assign vreg_rd1_i = vregs[vreg_rd1_addr_o];
    assign vreg_rd2_i = vregs[vreg_rd2_addr_o];
    assign vreg_rd3_i = vregs[vreg_rd3_addr_o];

    always @(posedge clk_i) begin
        if (vreg_wr_en_o) begin
            for (int b = 0; b < VREG_BYTES; b++) begin
                if (vreg_wr_mask_o[b]) begin
                    vregs[vreg_wr_addr_o][8*b +: 8] <= vreg_wr_o[8*b +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // reference model

    // every element of a register, vs1 is the first factor
    function automatic vreg_t ref_result(input mul_op_e op, input vsew_e sew,
                                         input vreg_t v1, input vreg_t v2, input vreg_t old_v);
        int          ew;
        logic [63:0] emask;
        logic [63:0] a, b, c, p, e;
        vreg_t       r;
        ew    = 8 << int'(sew);
        emask = (64'd1 << ew) - 64'd1;
        r     = '0;
        for (int i = 0; i < VREG_W / ew; i++) begin
            a = 64'(v1 >> (i * ew)) & emask;
            b = 64'(v2 >> (i * ew)) & emask;
            c = 64'(old_v >> (i * ew)) & emask;
            // vs1 signed only for VMULH, vs2 also for VMULHSU
            if (op == MUL_VMULH && a[ew-1]) a = a | ~emask;
            if ((op == MUL_VMULH || op == MUL_VMULHSU) && b[ew-1]) b = b | ~emask;
            p = a * b;
            case (op)
                MUL_VMULH, MUL_VMULHU, MUL_VMULHSU: e = (p >> ew) & emask;
                MUL_VMACC:  e = (c + p) & emask;
                MUL_VNMSAC: e = (c - p) & emask;
                default:    e = p & emask;
            endcase
            r = r | (vreg_t'(e) << (i * ew));
        end
        return r;
    endfunction

    // byte enabled when its element lies below vl
    function automatic vreg_mask_t ref_mask(input vsew_e sew, input vl_t vl);
        vreg_mask_t m;
        for (int j = 0; j < VREG_BYTES; j++) begin
            m[j] = ((j >> int'(sew)) < int'(vl));
        end
        return m;
    endfunction

    function automatic vreg_t merge_bytes(input vreg_t old_v, input vreg_t new_v,
                                          input vreg_mask_t m);
        vreg_t r;
        r = old_v;
        for (int j = 0; j < VREG_BYTES; j++) begin
            if (m[j]) r[8*j +: 8] = new_v[8*j +: 8];
        end
        return r;
    endfunction

    vmul_unit u_vmul_unit (
        .clk_i           (clk_i),
        .async_rst_ni    (async_rst_ni),
        .op_rdy_i        (op_rdy_i),
        .op_ack_o        (op_ack_o),
        .op_i            (op_i),
        .vsew_i          (vsew_i),
        .vl_i            (vl_i),
        .vs1_i           (vs1_i),
        .vs2_i           (vs2_i),
        .vd_i            (vd_i),
        .vreg_rd1_addr_o (vreg_rd1_addr_o),
        .vreg_rd1_i      (vreg_rd1_i),
        .vreg_rd2_addr_o (vreg_rd2_addr_o),
        .vreg_rd2_i      (vreg_rd2_i),
        .vreg_rd3_addr_o (vreg_rd3_addr_o),
        .vreg_rd3_i      (vreg_rd3_i),
        .vreg_wr_en_o    (vreg_wr_en_o),
        .vreg_wr_addr_o  (vreg_wr_addr_o),
        .vreg_wr_o       (vreg_wr_o),
        .vreg_wr_mask_o  (vreg_wr_mask_o)
    );

    `include "vmul_tb_tasks.svh"

    initial begin
        void'($urandom(32'h704659ec));
        err_cnt      = 0;
        cycle_cnt    = 0;
        async_rst_ni = 1'b0;
        op_rdy_i     = 1'b0;
        op_i         = MUL_VMUL;
        vsew_i       = VSEW_8;
        vl_i         = '0;
        vs1_i        = '0;
        vs2_i        = '0;
        vd_i         = '0;
        for (int r = 0; r < 32; r++) begin
            vregs[r] = {$urandom, $urandom, $urandom, $urandom};
        end
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        async_rst_ni = 1'b1;

        reset_quiet();
        low_products();
        high_products();
        accumulate_ops();
        partial_vl_masks();
        back_to_back();

        $display("errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+bench
logic/vmul_pkg.sv
logic/vmul_if.sv
logic/vmul_operand_fetch.sv
logic/vmul_lanes.sv
logic/vmul_result_pack.sv
logic/vmul_unit.sv
bench/vmul_tb.sv
